//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen            = 32;  // Data and address width
    localparam int reg_index_width = 5;   // rs1, rs2 and rd fields
    localparam int opcode_width    = 7;
    localparam int funct3_width    = 3;

    // Only the RV32I base opcodes that this decode stage understands.
    // Anything else falls to the default branches as an unknown opcode.
    typedef enum logic [opcode_width-1:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_e;

endpackage

`default_nettype wire

//--- rtl/idu_ctrl_pkg.sv
`default_nettype none

package idu_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,   // Signed compare that also serves blt and bge
        alu_sltu = 4'd3,   // Unsigned compare that also serves bltu and bgeu
        alu_xor  = 4'd4,
        alu_or   = 4'd5,
        alu_and  = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9,
        alu_eq   = 4'd10   // Equality for beq and bne
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_reg  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2   // lui adds the immediate to zero
    } src1_sel_e;

    typedef enum logic {
        src2_reg = 1'b0,
        src2_imm = 1'b1
    } src2_sel_e;

endpackage

`default_nettype wire

//--- rtl/idu_stage_reg.sv
`default_nettype none

module idu_stage_reg
    import rv_isa_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            flush,
    input  logic [xlen-1:0] inst,
    input  logic [xlen-1:0] pc,
    input  logic            valid_in,
    output logic            ready_in,
    output logic            valid_out,
    input  logic            ready_out,
    output logic [xlen-1:0] inst_held,
    output logic [xlen-1:0] pc_held
);

    logic accept;
    logic flush_pending;
    logic drop;

    assign ready_in = ready_out || !valid_out;  // Room once the held item leaves
    assign accept   = valid_in && ready_in;
    assign drop     = flush || flush_pending;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_out     <= 1'b0;
            flush_pending <= 1'b0;
            inst_held     <= '0;
        end else if (accept) begin
            valid_out     <= !drop;
            flush_pending <= 1'b0;
            inst_held     <= drop ? '0 : inst;  // A zero word decodes to no action
        end else begin
            flush_pending <= drop;  // Wait for the next accept
            if (ready_out) begin
                valid_out <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            pc_held <= pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/idu_imm_gen.sv
`default_nettype none

module idu_imm_gen
    import rv_isa_pkg::*;
(
    input  logic [xlen-1:0] inst_held,
    output logic [xlen-1:0] imm
);

    opcode_e opcode;
    logic    sign;

    assign opcode = opcode_e'(inst_held[opcode_width-1:0]);
    assign sign   = inst_held[31];

    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr: begin
                imm = {{(xlen-12){sign}}, inst_held[31:20]};  // Shift amounts pass through too
            end
            op_store: begin
                imm = {{(xlen-12){sign}}, inst_held[31:25], inst_held[11:7]};
            end
            op_branch: begin
                imm = {{(xlen-12){sign}}, inst_held[7], inst_held[30:25],
                       inst_held[11:8], 1'b0};
            end
            op_lui, op_auipc: begin
                imm = {inst_held[31:12], 12'b0};
            end
            op_jal: begin
                imm = {{(xlen-20){sign}}, inst_held[19:12], inst_held[20],
                       inst_held[30:21], 1'b0};
            end
            default: imm = '0;  // R format has no immediate
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/idu_decoder.sv
`default_nettype none

module idu_decoder
    import rv_isa_pkg::*;
    import idu_ctrl_pkg::*;
(
    input  logic [xlen-1:0] inst_held,
    output alu_op_e         alu_op,
    output src1_sel_e       src1_sel,
    output src2_sel_e       src2_sel,
    output logic            reg_wen,
    output logic            mem_wen,
    output logic            mem_ren,
    output logic            jump,
    output logic            branch,
    output logic            inv_flag
);

    opcode_e                 opcode;
    logic [funct3_width-1:0] funct3;
    logic                    funct7_b30;

    assign opcode     = opcode_e'(inst_held[opcode_width-1:0]);
    assign funct3     = inst_held[14:12];
    assign funct7_b30 = inst_held[30];

    // Shared by register and immediate arithmetic; only op_reg may subtract
    function automatic alu_op_e arith_op(input logic [funct3_width-1:0] f3,
                                         input logic sub_ok,
                                         input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = (sub_ok && alt) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        alu_op   = alu_add;
        src1_sel = src1_reg;
        src2_sel = src2_imm;
        reg_wen  = 1'b0;
        mem_wen  = 1'b0;
        mem_ren  = 1'b0;
        jump     = 1'b0;
        branch   = 1'b0;
        inv_flag = 1'b0;
        case (opcode)
            op_reg: begin
                alu_op   = arith_op(funct3, 1'b1, funct7_b30);
                src2_sel = src2_reg;
                reg_wen  = 1'b1;
            end
            op_imm: begin
                alu_op  = arith_op(funct3, 1'b0, funct7_b30);
                reg_wen = 1'b1;
            end
            op_load: begin
                reg_wen = 1'b1;
                mem_ren = 1'b1;
            end
            op_store: mem_wen = 1'b1;
            op_branch: begin
                src2_sel = src2_reg;
                branch   = 1'b1;
                case (funct3[2:1])
                    2'b00:   alu_op = alu_eq;
                    2'b10:   alu_op = alu_slt;
                    2'b11:   alu_op = alu_sltu;
                    default: alu_op = alu_add;
                endcase
                inv_flag = funct3[0] && (funct3[2:1] != 2'b01);  // bne, bge, bgeu
            end
            op_jal: begin
                src1_sel = src1_pc;
                reg_wen  = 1'b1;
                jump     = 1'b1;
            end
            op_jalr: begin
                reg_wen = 1'b1;
                jump    = 1'b1;
            end
            op_lui: begin
                src1_sel = src1_zero;
                reg_wen  = 1'b1;
            end
            op_auipc: begin
                src1_sel = src1_pc;
                reg_wen  = 1'b1;
            end
            default: alu_op = alu_add;  // Unknown opcode stays inert
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/idu_regfile.sv
`default_nettype none

module idu_regfile
    import rv_isa_pkg::*;
#(
    parameter int reg_count = 32
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [reg_index_width-1:0] rs1,
    input  logic [reg_index_width-1:0] rs2,
    output logic [xlen-1:0]            rs1_value,
    output logic [xlen-1:0]            rs2_value,
    input  logic                       wb_wen,
    input  logic [reg_index_width-1:0] wb_rd,
    input  logic [xlen-1:0]            wb_value
);

    localparam int index_bits = $clog2(reg_count);

    logic [xlen-1:0]       regs [reg_count];
    logic [index_bits-1:0] rs1_idx;
    logic [index_bits-1:0] rs2_idx;
    logic [index_bits-1:0] wb_idx;

    // With 16 registers the top index bit drops out here
    assign rs1_idx = rs1[index_bits-1:0];
    assign rs2_idx = rs2[index_bits-1:0];
    assign wb_idx  = wb_rd[index_bits-1:0];

    assign rs1_value = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_value = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wen && wb_idx != '0) begin
            regs[wb_idx] <= wb_value;  // No bypass to the read ports
        end
    end

endmodule

`default_nettype wire

//--- rtl/idu_top.sv
`default_nettype none

module idu_top
    import rv_isa_pkg::*;
    import idu_ctrl_pkg::*;
#(
    parameter int reg_count = 32
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush,
    input  logic [xlen-1:0]            inst,
    input  logic [xlen-1:0]            pc,
    input  logic                       valid_in,
    output logic                       ready_in,
    output logic                       valid_out,
    input  logic                       ready_out,
    input  logic                       wb_wen,
    input  logic [reg_index_width-1:0] wb_rd,
    input  logic [xlen-1:0]            wb_value,
    output logic [xlen-1:0]            pc_out,
    output logic [reg_index_width-1:0] rd,
    output logic [reg_index_width-1:0] rs1,
    output logic [reg_index_width-1:0] rs2,
    output logic [funct3_width-1:0]    funct3,
    output logic [xlen-1:0]            imm,
    output logic [xlen-1:0]            rs1_value,
    output logic [xlen-1:0]            rs2_value,
    output alu_op_e                    alu_op,
    output src1_sel_e                  src1_sel,
    output src2_sel_e                  src2_sel,
    output logic                       reg_wen,
    output logic                       mem_wen,
    output logic                       mem_ren,
    output logic                       jump,
    output logic                       branch,
    output logic                       inv_flag
);

    logic [xlen-1:0] inst_held;

    assign rd     = inst_held[11:7];
    assign rs1    = inst_held[19:15];
    assign rs2    = inst_held[24:20];
    assign funct3 = inst_held[14:12];

    idu_stage_reg u_stage_reg (
        .clock(clock), .reset(reset), .flush(flush),
        .inst(inst), .pc(pc),
        .valid_in(valid_in), .ready_in(ready_in),
        .valid_out(valid_out), .ready_out(ready_out),
        .inst_held(inst_held), .pc_held(pc_out)
    );

    idu_imm_gen u_imm_gen (.inst_held(inst_held), .imm(imm));

    idu_decoder u_decoder (
        .inst_held(inst_held), .alu_op(alu_op),
        .src1_sel(src1_sel), .src2_sel(src2_sel),
        .reg_wen(reg_wen), .mem_wen(mem_wen), .mem_ren(mem_ren),
        .jump(jump), .branch(branch), .inv_flag(inv_flag)
    );

    idu_regfile #(.reg_count(reg_count)) u_regfile (
        .clock(clock), .reset(reset),
        .rs1(rs1), .rs2(rs2),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .wb_wen(wb_wen), .wb_rd(wb_rd), .wb_value(wb_value)
    );

endmodule

`default_nettype wire

//--- tb/tb_idu_chk.sv
`default_nettype none

module tb_idu_chk (
    input logic        clock,
    input logic        reset,
    input logic        valid_out,
    input logic        ready_out,
    input logic [31:0] inst_held,
    input logic [31:0] pc_out,
    input logic        mem_wen,
    input logic        mem_ren,
    input logic [4:0]  rs1,
    input logic [31:0] rs1_value
);

    timeunit 1ns;
    timeprecision 1ps;

    assert property (@(posedge clock) reset |=> !valid_out)
        else $error("valid_out high during or just after reset");

    // A stalled item must not change until execute takes it
    assert property (@(posedge clock) disable iff (reset)
        (valid_out && !ready_out) |=> ($stable(inst_held) && $stable(pc_out)))
        else $error("held item changed under back-pressure");

    assert property (@(posedge clock) disable iff (reset) !(mem_wen && mem_ren))
        else $error("mem_wen and mem_ren high together");

    assert property (@(posedge clock) disable iff (reset) (rs1 == 5'd0) |-> (rs1_value == '0))
        else $error("x0 read back nonzero");

endmodule

bind idu_top tb_idu_chk chk (
    .clock(clock), .reset(reset), .valid_out(valid_out), .ready_out(ready_out),
    .inst_held(inst_held), .pc_out(pc_out), .mem_wen(mem_wen), .mem_ren(mem_ren),
    .rs1(rs1), .rs1_value(rs1_value)
);

`default_nettype wire

//--- tb/tb_idu.sv
`default_nettype none

module tb_idu
    import rv_isa_pkg::*;
    import idu_ctrl_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int test_cycles = 600;  // Rough sum over all tests with slack

    logic clock = 1'b0;
    logic reset, flush, valid_in, ready_in, valid_out, ready_out, wb_wen;
    logic [31:0] inst, pc, wb_value, pc_out, imm, rs1_value, rs2_value;
    logic [4:0] wb_rd, rd, rs1, rs2;
    logic [2:0] funct3;
    alu_op_e alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic reg_wen, mem_wen, mem_ren, jump, branch, inv_flag;
    logic [31:0] rng_state = 32'h5330d706;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    idu_top #(.reg_count(32)) UUT (.*);

    always #10 clock = ~clock;

    initial begin
        #(test_cycles * 20 + 2000);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] make_inst(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [6:0] op);
        return {f7, 5'd3, 5'd9, f3, 5'd17, op};
    endfunction

    // Sign extension by arithmetic shifts and then the scattered low bits
    function automatic logic [31:0] ref_imm(input logic [31:0] i);
        logic signed [31:0] s;
        logic [31:0] sh20;
        logic [31:0] sh19;
        logic [31:0] sh11;
        s = i;
        sh20 = s >>> 20;
        sh19 = s >>> 19;
        sh11 = s >>> 11;
        case (i[6:0])
            op_imm, op_load, op_jalr: return sh20;
            op_store: return (sh20 & ~32'h1f) | {27'd0, i[11:7]};
            op_branch: return (sh19 & ~32'hfff) | {20'd0, i[7], i[30:25], i[11:8], 1'b0};
            op_lui, op_auipc: return i & 32'hfffff000;
            op_jal: return (sh11 & ~32'hfffff) | {12'd0, i[19:12], i[20], i[30:21], 1'b0};
            default: return 32'd0;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_alu_op(input alu_op_e got, input alu_op_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch alu_op got %h expected %h", got, exp);
        end
    endtask

    task automatic check_src1(input src1_sel_e got, input src1_sel_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch src1_sel got %h expected %h", got, exp);
        end
    endtask

    task automatic check_src2(input src2_sel_e got, input src2_sel_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch src2_sel got %h expected %h", got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    // Returns on the falling edge right after the accept edge
    task automatic issue(input logic [31:0] i, input logic [31:0] p, input logic fl);
        int waited;
        waited = 0;
        @(negedge clock);
        inst = i;
        pc = p;
        valid_in = 1'b1;
        flush = fl;
        while (!ready_in && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (!ready_in) begin
            errors++;
            $display("ready_in stayed low so the instruction was never accepted");
        end
        @(negedge clock);
        valid_in = 1'b0;
        flush = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] r, input logic [31:0] v);
        @(negedge clock);
        wb_wen = 1'b1;
        wb_rd = r;
        wb_value = v;
        @(negedge clock);
        wb_wen = 1'b0;
    endtask

    task automatic decode_case(input logic [31:0] i, input alu_op_e a, input src1_sel_e s1,
                               input src2_sel_e s2, input logic [5:0] fl);
        logic [31:0] p;
        p = next_rand();
        issue(i, p, 1'b0);
        check_bit("valid_out", valid_out, 1'b1);
        check_alu_op(alu_op, a);
        check_src1(src1_sel, s1);
        check_src2(src2_sel, s2);
        check_bit("reg_wen", reg_wen, fl[5]);
        check_bit("mem_ren", mem_ren, fl[4]);
        check_bit("mem_wen", mem_wen, fl[3]);
        check_bit("jump", jump, fl[2]);
        check_bit("branch", branch, fl[1]);
        check_bit("inv_flag", inv_flag, fl[0]);
        check_word("rd", {27'd0, rd}, {27'd0, i[11:7]});
        check_word("rs1", {27'd0, rs1}, {27'd0, i[19:15]});
        check_word("rs2", {27'd0, rs2}, {27'd0, i[24:20]});
        check_word("funct3", {29'd0, funct3}, {29'd0, i[14:12]});
        check_word("pc_out", pc_out, p);
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        check_bit("valid_out", valid_out, 1'b0);
        check_bit("ready_in", ready_in, 1'b1);
        check_bit("reg_wen", reg_wen, 1'b0);
        issue(make_inst(7'h00, 3'd0, op_imm), 32'h100, 1'b0);
        check_bit("valid_out", valid_out, 1'b1);
        report_test("reset", e);
    endtask

    task automatic test_decode();
        int e;
        e = errors;
        decode_case(make_inst(7'h00, 3'd0, op_reg), alu_add, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h20, 3'd0, op_reg), alu_sub, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h00, 3'd1, op_reg), alu_sll, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h00, 3'd2, op_reg), alu_slt, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h00, 3'd3, op_reg), alu_sltu, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h00, 3'd4, op_reg), alu_xor, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h00, 3'd5, op_reg), alu_srl, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h20, 3'd5, op_reg), alu_sra, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h00, 3'd6, op_reg), alu_or, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h00, 3'd7, op_reg), alu_and, src1_reg, src2_reg, 6'b100000);
        decode_case(make_inst(7'h20, 3'd0, op_imm), alu_add, src1_reg, src2_imm, 6'b100000);
        decode_case(make_inst(7'h00, 3'd2, op_imm), alu_slt, src1_reg, src2_imm, 6'b100000);
        decode_case(make_inst(7'h20, 3'd5, op_imm), alu_sra, src1_reg, src2_imm, 6'b100000);
        decode_case(make_inst(7'h00, 3'd7, op_imm), alu_and, src1_reg, src2_imm, 6'b100000);
        decode_case(make_inst(7'h00, 3'd2, op_load), alu_add, src1_reg, src2_imm, 6'b110000);
        decode_case(make_inst(7'h00, 3'd2, op_store), alu_add, src1_reg, src2_imm, 6'b001000);
        decode_case(make_inst(7'h00, 3'd0, op_branch), alu_eq, src1_reg, src2_reg, 6'b000010);
        decode_case(make_inst(7'h00, 3'd1, op_branch), alu_eq, src1_reg, src2_reg, 6'b000011);
        decode_case(make_inst(7'h00, 3'd4, op_branch), alu_slt, src1_reg, src2_reg, 6'b000010);
        decode_case(make_inst(7'h00, 3'd5, op_branch), alu_slt, src1_reg, src2_reg, 6'b000011);
        decode_case(make_inst(7'h00, 3'd6, op_branch), alu_sltu, src1_reg, src2_reg, 6'b000010);
        decode_case(make_inst(7'h00, 3'd7, op_branch), alu_sltu, src1_reg, src2_reg, 6'b000011);
        decode_case(make_inst(7'h00, 3'd0, op_jal), alu_add, src1_pc, src2_imm, 6'b100100);
        decode_case(make_inst(7'h00, 3'd0, op_jalr), alu_add, src1_reg, src2_imm, 6'b100100);
        decode_case(make_inst(7'h00, 3'd0, op_lui), alu_add, src1_zero, src2_imm, 6'b100000);
        decode_case(make_inst(7'h00, 3'd0, op_auipc), alu_add, src1_pc, src2_imm, 6'b100000);
        decode_case(make_inst(7'h00, 3'd0, 7'h7f), alu_add, src1_reg, src2_imm, 6'b000000);
        report_test("decode", e);
    endtask

    task automatic test_imm();
        opcode_e ops[9];
        logic [31:0] i;
        int e;
        e = errors;
        ops = '{op_reg, op_imm, op_load, op_store, op_branch, op_jal, op_jalr, op_lui, op_auipc};
        foreach (ops[k]) begin
            for (int n = 0; n < 4; n++) begin
                i = {next_rand() & 32'hffffff80} | {25'd0, ops[k]};
                issue(i, 32'h0, 1'b0);
                check_word("imm", imm, ref_imm(i));
            end
        end
        report_test("immediates", e);
    endtask

    task automatic test_regfile();
        logic [4:0] r;
        logic [31:0] v;
        int e;
        e = errors;
        write_reg(5'd0, 32'hdeadbeef);
        issue(32'h00000033, 32'h0, 1'b0);
        check_word("rs1_value", rs1_value, 32'h0);
        check_word("rs2_value", rs2_value, 32'h0);
        for (int n = 0; n < 6; n++) begin
            r = 5'(next_rand() % 31 + 1);
            v = next_rand();
            write_reg(r, v);
            issue({7'h00, r, r, 3'd0, 5'd1, op_reg}, 32'h0, 1'b0);
            check_word("rs1_value", rs1_value, v);
            check_word("rs2_value", rs2_value, v);
        end
        // Write the register that is being read and see the old value until the edge
        @(negedge clock);
        wb_wen = 1'b1;
        wb_rd = r;
        wb_value = ~v;
        check_word("rs1_value", rs1_value, v);
        @(negedge clock);
        wb_wen = 1'b0;
        check_word("rs1_value", rs1_value, ~v);
        report_test("regfile", e);
    endtask

    task automatic test_backpressure();
        logic [31:0] a;
        logic [31:0] b;
        int e;
        e = errors;
        a = {12'h7f0, 5'd4, 3'd2, 5'd8, op_load};
        b = make_inst(7'h00, 3'd1, op_branch);
        ready_out = 1'b0;
        issue(a, 32'h2000, 1'b0);
        // The next instruction waits at the input while the stage is stalled
        inst = b;
        pc = 32'h2004;
        valid_in = 1'b1;
        for (int n = 0; n < 4; n++) begin
            check_bit("valid_out", valid_out, 1'b1);
            check_bit("ready_in", ready_in, 1'b0);
            check_word("pc_out", pc_out, 32'h2000);
            check_word("imm", imm, 32'h000007f0);
            check_bit("mem_ren", mem_ren, 1'b1);
            check_word("rd", {27'd0, rd}, 32'd8);
            @(negedge clock);
        end
        ready_out = 1'b1;
        @(negedge clock);
        valid_in = 1'b0;
        check_bit("valid_out", valid_out, 1'b1);
        check_word("pc_out", pc_out, 32'h2004);
        check_alu_op(alu_op, alu_eq);
        check_bit("inv_flag", inv_flag, 1'b1);
        report_test("backpressure", e);
    endtask

    task automatic test_flush();
        int e;
        e = errors;
        issue(make_inst(7'h00, 3'd0, op_jal), 32'h300, 1'b1);
        check_bit("valid_out", valid_out, 1'b0);
        check_bit("jump", jump, 1'b0);
        check_bit("reg_wen", reg_wen, 1'b0);
        decode_case(make_inst(7'h00, 3'd4, op_reg), alu_xor, src1_reg, src2_reg, 6'b100000);
        @(negedge clock);
        flush = 1'b1;
        @(negedge clock);
        flush = 1'b0;
        issue(make_inst(7'h00, 3'd2, op_store), 32'h400, 1'b0);
        check_bit("valid_out", valid_out, 1'b0);
        check_bit("mem_wen", mem_wen, 1'b0);
        decode_case(make_inst(7'h00, 3'd0, op_lui), alu_add, src1_zero, src2_imm, 6'b100000);
        report_test("flush", e);
    endtask

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        valid_in = 1'b0;
        ready_out = 1'b1;
        inst = '0;
        pc = '0;
        wb_wen = 1'b0;
        wb_rd = '0;
        wb_value = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_reset();
        test_decode();
        test_imm();
        test_regfile();
        test_backpressure();
        test_flush();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- idu.f
rtl/rv_isa_pkg.sv
rtl/idu_ctrl_pkg.sv
rtl/idu_stage_reg.sv
rtl/idu_imm_gen.sv
rtl/idu_decoder.sv
rtl/idu_regfile.sv
rtl/idu_top.sv
tb/tb_idu_chk.sv
tb/tb_idu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -f idu.f --top-module tb_idu -o sim_idu
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_idu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
